//--- Bender.yml
package:
  name: legv8_pipeline

sources:
  - cpu_pkg.sv
  - fwd_if.sv
  - pipe_reg.sv
  - fetch_unit.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - mem_wb_stage.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_asserts.sv
      - tb_cpu_top.sv

//--- compile.f
cpu_pkg.sv
fwd_if.sv
pipe_reg.sv
fetch_unit.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
cpu_asserts.sv
tb_cpu_top.sv

//--- cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts #(
  parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
  input wire logic                     CLOCK,
  input wire logic                     rst_n,
  input wire logic [cpu_pkg::xlen-1:0] pc,
  input wire logic [cpu_pkg::xlen-1:0] mem_addr,
  input wire logic [cpu_pkg::xlen-1:0] mem_wdata,
  input wire logic                     mem_read,
  input wire logic                     mem_write,
  input wire logic                     stall,
  input wire logic                     redirect,
  input wire logic [cpu_pkg::xlen-1:0] redirect_pc
);

  localparam int unsigned n_stores = 11;

  // Register i starts at i, data word i starts at 5*i
  localparam logic [cpu_pkg::xlen-1:0] exp_addr [n_stores] =
    '{0, 8, 16, 24, 32, 40, 56, 64, 96, 112, 144};
  localparam logic [cpu_pkg::xlen-1:0] exp_data [n_stores] =
    '{12, 16, 4, 8, 25, 0, 33, 10, 14, 16, 20};
  localparam string exp_test [n_stores] = '{"forwarding", "forwarding", "forwarding",
    "forwarding", "forwarding", "zero_reg", "load_use", "cbz", "cbz", "branch", "branch"};

  int unsigned              store_idx;
  int unsigned              fail_count = 0;
  logic                     fail_is_value = 1'b0;
  string                    fail_test;
  string                    fail_text;
  logic [cpu_pkg::xlen-1:0] fail_exp, fail_act;
  logic                     past_valid = 1'b0;

  task automatic record_failure(input string text);
    if (fail_count == 0) fail_text = text;
    fail_count++;
  endtask

  task automatic record_value_failure(input string test,
                                      input logic [cpu_pkg::xlen-1:0] expected, actual);
    if (fail_count == 0) begin
      fail_is_value = 1'b1;
      fail_test     = test;
      fail_exp      = expected;
      fail_act      = actual;
    end
    fail_count++;
  endtask

  always_ff @(posedge CLOCK) past_valid <= 1'b1;

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) store_idx <= 0;
    else if (mem_write) store_idx <= store_idx + 1; // Next table entry
  end

  reset_state: assert property (@(posedge CLOCK)
    past_valid && (!rst_n || $rose(rst_n)) |-> pc == reset_pc && !mem_read && !mem_write)
    else begin
      record_failure("pc or memory strobes left their reset values during reset");
      $error("reset state wrong");
    end

  pc_step: assert property (@(posedge CLOCK) disable iff (!rst_n)
    !redirect && !stall |=> pc == $past(pc) + cpu_pkg::xlen'(4))
    else begin
      record_failure("pc did not advance by four");
      $error("pc step wrong");
    end

  pc_hold: assert property (@(posedge CLOCK) disable iff (!rst_n)
    stall && !redirect |=> pc == $past(pc))
    else begin
      record_failure("pc moved during a load-use stall");
      $error("pc hold wrong");
    end

  pc_branch: assert property (@(posedge CLOCK) disable iff (!rst_n)
    redirect |=> pc == $past(redirect_pc))
    else begin
      record_failure("pc did not take the branch target");
      $error("pc redirect wrong");
    end

  store_count_ok: assert property (@(posedge CLOCK) disable iff (!rst_n)
    mem_write |-> store_idx < n_stores)
    else begin
      record_failure("a store appeared after the last expected one");
      $error("extra store");
    end

  store_addr_ok: assert property (@(posedge CLOCK) disable iff (!rst_n)
    mem_write && store_idx < n_stores |-> mem_addr == exp_addr[store_idx])
    else begin
      record_value_failure(exp_test[$sampled(store_idx)], exp_addr[$sampled(store_idx)],
                           $sampled(mem_addr));
      $error("store address wrong");
    end

  store_data_ok: assert property (@(posedge CLOCK) disable iff (!rst_n)
    mem_write && store_idx < n_stores |-> mem_wdata == exp_data[store_idx])
    else begin
      record_value_failure(exp_test[$sampled(store_idx)], exp_data[$sampled(store_idx)],
                           $sampled(mem_wdata));
      $error("store data wrong");
    end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int unsigned xlen       = 64;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned zero_reg   = 31;

  localparam logic [10:0] op_add  = 11'b10001011000;
  localparam logic [10:0] op_sub  = 11'b11001011000;
  localparam logic [10:0] op_and  = 11'b10001010000;
  localparam logic [10:0] op_orr  = 11'b10101010000;
  localparam logic [10:0] op_ldur = 11'b11111000010;
  localparam logic [10:0] op_stur = 11'b11111000000;
  localparam logic [9:0]  op_addi = 10'b1001000100;
  localparam logic [9:0]  op_subi = 10'b1101000100;
  localparam logic [7:0]  op_cbz  = 8'b10110100;
  localparam logic [5:0]  op_b    = 6'b000101;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    cls_mem    = 2'b00, // Address add
    cls_branch = 2'b01, // Pass B for CBZ
    cls_rtype  = 2'b10  // Operation from opcode
  } alu_class_e;

  typedef struct packed {
    alu_class_e alu_class;
    logic       alu_src;
    logic       zero_branch;
    logic       uncond_branch;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       mem_to_reg;
  } ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       imm;
    logic [10:0]           opcode;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
  } id_ex_t;

  typedef struct packed {
    logic                  zero_branch;
    logic                  uncond_branch;
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    logic                  mem_to_reg;
    logic [xlen-1:0]       branch_target;
    logic                  alu_zero;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       store_data;
    logic [reg_addr_w-1:0] rd;
  } ex_mem_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_to_reg;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       load_data;
    logic [reg_addr_w-1:0] rd;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
  input  wire logic                      CLOCK,
  input  wire logic                      rst_n,
  input  wire logic [31:0]               instr,
  input  wire logic [cpu_pkg::xlen-1:0]  mem_rdata,
  output logic      [cpu_pkg::xlen-1:0]  pc,
  output logic      [cpu_pkg::xlen-1:0]  mem_addr,
  output logic      [cpu_pkg::xlen-1:0]  mem_wdata,
  output logic                           mem_read,
  output logic                           mem_write
);

  logic                     stall, redirect;
  logic [cpu_pkg::xlen-1:0] redirect_pc;
  cpu_pkg::if_id_t          if_id_d, if_id_q;
  cpu_pkg::id_ex_t          id_ex_d, id_ex_q;
  cpu_pkg::ex_mem_t         ex_mem_d, ex_mem_q;
  cpu_pkg::mem_wb_t         mem_wb_d, mem_wb_q;

  fwd_if fwd ();

  assign fwd.mem_rd        = ex_mem_q.rd;
  assign fwd.mem_reg_write = ex_mem_q.reg_write;
  assign fwd.mem_result    = ex_mem_q.alu_result;

  fetch_unit #(.reset_pc(reset_pc)) i_fetch_unit (
    .CLOCK(CLOCK), .rst_n(rst_n), .stall(stall), .redirect(redirect),
    .redirect_pc(redirect_pc), .pc(pc)
  );

  assign if_id_d.pc    = pc;
  assign if_id_d.instr = instr;

  pipe_reg #(.payload_t(cpu_pkg::if_id_t), .bubble('0)) i_if_id (
    .CLOCK(CLOCK), .rst_n(rst_n), .enable(!stall), .flush(redirect),
    .d(if_id_d), .q(if_id_q)
  );

  decode_stage i_decode_stage (
    .CLOCK(CLOCK), .rst_n(rst_n), .if_id(if_id_q), .ex_mem_read(id_ex_q.ctrl.mem_read),
    .ex_rd(id_ex_q.rd), .wr(fwd), .id_ex(id_ex_d), .stall(stall)
  );

  pipe_reg #(.payload_t(cpu_pkg::id_ex_t), .bubble('0)) i_id_ex (
    .CLOCK(CLOCK), .rst_n(rst_n), .enable(1'b1), .flush(redirect),
    .d(id_ex_d), .q(id_ex_q)
  );

  execute_stage i_execute_stage (.id_ex(id_ex_q), .fwd(fwd), .ex_mem(ex_mem_d));

  pipe_reg #(.payload_t(cpu_pkg::ex_mem_t), .bubble('0)) i_ex_mem (
    .CLOCK(CLOCK), .rst_n(rst_n), .enable(1'b1), .flush(redirect),
    .d(ex_mem_d), .q(ex_mem_q)
  );

  mem_wb_stage i_mem_wb_stage (
    .ex_mem(ex_mem_q), .mem_rdata(mem_rdata), .mem_wb(mem_wb_q),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_read(mem_read),
    .mem_write(mem_write), .redirect(redirect), .redirect_pc(redirect_pc),
    .mem_wb_next(mem_wb_d), .fwd(fwd)
  );

  pipe_reg #(.payload_t(cpu_pkg::mem_wb_t), .bubble('0)) i_mem_wb (
    .CLOCK(CLOCK), .rst_n(rst_n), .enable(1'b1), .flush(1'b0), // Branch itself retires
    .d(mem_wb_d), .q(mem_wb_q)
  );

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire logic                           CLOCK,
  input  wire logic                           rst_n,
  input  wire cpu_pkg::if_id_t                if_id,
  input  wire logic                           ex_mem_read,
  input  wire logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
  fwd_if.rf_sink                              wr,
  output cpu_pkg::id_ex_t                     id_ex,
  output logic                                stall
);

  localparam int unsigned xl = cpu_pkg::xlen;

  logic [31:0]                     instr;
  logic [10:0]                     opcode;
  logic [cpu_pkg::reg_addr_w-1:0]  rn, rm, rd, rs2;
  logic [xl-1:0]                   rs1_data, rs2_data, imm;
  logic                            is_b, is_cbz, is_alu_imm, is_ldur, is_stur, is_rtype;
  logic                            uses_rs1, uses_rs2;
  cpu_pkg::ctrl_t                  ctrl;

  assign instr  = if_id.instr;
  assign opcode = instr[31:21];
  assign rn     = instr[9:5];
  assign rm     = instr[20:16];
  assign rd     = instr[4:0];

  assign is_b       = opcode[10:5] == cpu_pkg::op_b;
  assign is_cbz     = opcode[10:3] == cpu_pkg::op_cbz;
  assign is_alu_imm = (opcode[10:1] == cpu_pkg::op_addi) || (opcode[10:1] == cpu_pkg::op_subi);
  assign is_ldur    = opcode == cpu_pkg::op_ldur;
  assign is_stur    = opcode == cpu_pkg::op_stur;
  assign is_rtype   = (opcode == cpu_pkg::op_add) || (opcode == cpu_pkg::op_sub) ||
                      (opcode == cpu_pkg::op_and) || (opcode == cpu_pkg::op_orr);

  assign rs2 = (is_stur || is_cbz) ? rd : rm; // Rt lives in the Rd field

  always_comb begin
    ctrl = '0;
    if (is_b) begin
      ctrl.alu_class     = cpu_pkg::cls_branch;
      ctrl.uncond_branch = 1'b1;
    end else if (is_cbz) begin
      ctrl.alu_class   = cpu_pkg::cls_branch;
      ctrl.zero_branch = 1'b1;
    end else if (is_alu_imm) begin
      ctrl.alu_class = cpu_pkg::cls_rtype;
      ctrl.alu_src   = 1'b1;
      ctrl.reg_write = 1'b1;
    end else if (is_ldur) begin
      ctrl.alu_src    = 1'b1;
      ctrl.mem_read   = 1'b1;
      ctrl.reg_write  = 1'b1;
      ctrl.mem_to_reg = 1'b1;
    end else if (is_stur) begin
      ctrl.alu_src   = 1'b1;
      ctrl.mem_write = 1'b1;
    end else if (is_rtype) begin
      ctrl.alu_class = cpu_pkg::cls_rtype;
      ctrl.reg_write = 1'b1;
    end
  end

  always_comb begin
    if (is_b) imm = {{(xl-26){instr[25]}}, instr[25:0]};
    else if (is_cbz) imm = {{(xl-19){instr[23]}}, instr[23:5]};
    else if (is_alu_imm) imm = {{(xl-12){1'b0}}, instr[21:10]}; // ALU immediate is unsigned
    else imm = {{(xl-9){instr[20]}}, instr[20:12]};
  end

  // Load-use check only against sources the instruction really reads
  assign uses_rs1 = ctrl.reg_write | ctrl.mem_write;
  assign uses_rs2 = (ctrl.reg_write & ~ctrl.alu_src) | ctrl.mem_write | ctrl.zero_branch;
  assign stall    = ex_mem_read && (ex_rd != cpu_pkg::reg_addr_w'(cpu_pkg::zero_reg)) &&
                    ((uses_rs1 && ex_rd == rn) || (uses_rs2 && ex_rd == rs2));

  reg_file i_reg_file (
    .CLOCK    (CLOCK),
    .rst_n    (rst_n),
    .rs1      (rn),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (wr)
  );

  always_comb begin
    id_ex.ctrl     = stall ? '0 : ctrl; // Bubble while held
    id_ex.pc       = if_id.pc;
    id_ex.rs1_data = rs1_data;
    id_ex.rs2_data = rs2_data;
    id_ex.imm      = imm;
    id_ex.opcode   = opcode;
    id_ex.rd       = rd;
    id_ex.rs1      = rn;
    id_ex.rs2      = rs2;
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire cpu_pkg::id_ex_t id_ex,
  fwd_if.fwd_sink              fwd,
  output cpu_pkg::ex_mem_t     ex_mem
);

  logic [cpu_pkg::xlen-1:0] op_a, op_b_reg, op_b, alu_result;
  cpu_pkg::alu_op_e         alu_op;

  // Newest producer first: MEM, then WB, then the register value
  function automatic logic [cpu_pkg::xlen-1:0] fwd_operand(
    input logic [cpu_pkg::reg_addr_w-1:0] src,
    input logic [cpu_pkg::xlen-1:0]       reg_val
  );
    logic live;
    live = src != cpu_pkg::reg_addr_w'(cpu_pkg::zero_reg);
    if (live && fwd.mem_reg_write && fwd.mem_rd == src) return fwd.mem_result;
    if (live && fwd.wb_reg_write && fwd.wb_rd == src) return fwd.wb_data;
    return reg_val;
  endfunction

  always_comb begin
    op_a     = fwd_operand(id_ex.rs1, id_ex.rs1_data);
    op_b_reg = fwd_operand(id_ex.rs2, id_ex.rs2_data);
  end

  assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;

  always_comb begin
    case (id_ex.ctrl.alu_class)
      cpu_pkg::cls_branch: alu_op = cpu_pkg::alu_pass_b;
      cpu_pkg::cls_rtype: begin
        if (id_ex.opcode == cpu_pkg::op_sub || id_ex.opcode[10:1] == cpu_pkg::op_subi)
          alu_op = cpu_pkg::alu_sub;
        else if (id_ex.opcode == cpu_pkg::op_and) alu_op = cpu_pkg::alu_and;
        else if (id_ex.opcode == cpu_pkg::op_orr) alu_op = cpu_pkg::alu_or;
        else alu_op = cpu_pkg::alu_add; // ADD and ADDI
      end
      default: alu_op = cpu_pkg::alu_add; // LDUR/STUR address
    endcase
  end

  always_comb begin
    case (alu_op)
      cpu_pkg::alu_sub:    alu_result = op_a - op_b;
      cpu_pkg::alu_and:    alu_result = op_a & op_b;
      cpu_pkg::alu_or:     alu_result = op_a | op_b;
      cpu_pkg::alu_pass_b: alu_result = op_b; // CBZ tests Rt
      default:             alu_result = op_a + op_b;
    endcase
  end

  always_comb begin
    ex_mem.zero_branch   = id_ex.ctrl.zero_branch;
    ex_mem.uncond_branch = id_ex.ctrl.uncond_branch;
    ex_mem.mem_read      = id_ex.ctrl.mem_read;
    ex_mem.mem_write     = id_ex.ctrl.mem_write;
    ex_mem.reg_write     = id_ex.ctrl.reg_write;
    ex_mem.mem_to_reg    = id_ex.ctrl.mem_to_reg;
    ex_mem.branch_target = id_ex.pc + (id_ex.imm << 2);
    ex_mem.alu_zero      = alu_result == '0;
    ex_mem.alu_result    = alu_result;
    ex_mem.store_data    = op_b_reg;
    ex_mem.rd            = id_ex.rd;
  end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
  input  wire logic                      CLOCK,
  input  wire logic                      rst_n,
  input  wire logic                      stall,
  input  wire logic                      redirect,
  input  wire logic [cpu_pkg::xlen-1:0]  redirect_pc,
  output logic      [cpu_pkg::xlen-1:0]  pc
);

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (redirect) begin // Taken branch from MEM
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + cpu_pkg::xlen'(4);
    end
  end

endmodule

`default_nettype wire

//--- fwd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fwd_if;
  logic [cpu_pkg::reg_addr_w-1:0] mem_rd;
  logic                           mem_reg_write;
  logic [cpu_pkg::xlen-1:0]       mem_result;    // EX/MEM ALU result
  logic [cpu_pkg::reg_addr_w-1:0] wb_rd;
  logic                           wb_reg_write;
  logic [cpu_pkg::xlen-1:0]       wb_data;       // Selected writeback value

  modport ex_src (output mem_rd, mem_reg_write, mem_result);
  modport wb_src (output wb_rd, wb_reg_write, wb_data);
  modport fwd_sink (
    input mem_rd, mem_reg_write, mem_result,
    input wb_rd, wb_reg_write, wb_data
  );
  modport rf_sink (input wb_rd, wb_reg_write, wb_data);
endinterface

`default_nettype wire

//--- mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
  input  wire cpu_pkg::ex_mem_t          ex_mem,
  input  wire logic [cpu_pkg::xlen-1:0]  mem_rdata,
  input  wire cpu_pkg::mem_wb_t          mem_wb,
  output logic      [cpu_pkg::xlen-1:0]  mem_addr,
  output logic      [cpu_pkg::xlen-1:0]  mem_wdata,
  output logic                           mem_read,
  output logic                           mem_write,
  output logic                           redirect,
  output logic      [cpu_pkg::xlen-1:0]  redirect_pc,
  output cpu_pkg::mem_wb_t               mem_wb_next,
  fwd_if.wb_src                          fwd
);

  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;
  assign mem_read  = ex_mem.mem_read;
  assign mem_write = ex_mem.mem_write;

  assign redirect    = ex_mem.uncond_branch | (ex_mem.zero_branch & ex_mem.alu_zero);
  assign redirect_pc = ex_mem.branch_target;

  always_comb begin
    mem_wb_next.reg_write  = ex_mem.reg_write;
    mem_wb_next.mem_to_reg = ex_mem.mem_to_reg;
    mem_wb_next.alu_result = ex_mem.alu_result;
    mem_wb_next.load_data  = mem_rdata;
    mem_wb_next.rd         = ex_mem.rd;
  end

  assign fwd.wb_rd        = mem_wb.rd;
  assign fwd.wb_reg_write = mem_wb.reg_write;
  assign fwd.wb_data      = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

//--- pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type      payload_t = logic,
  parameter payload_t bubble    = '0
) (
  input  wire logic     CLOCK,
  input  wire logic     rst_n,
  input  wire logic     enable,
  input  wire logic     flush,
  input  wire payload_t d,
  output payload_t      q
);

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      q <= bubble;
    end else if (flush) begin // Flush beats hold
      q <= bubble;
    end else if (enable) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic                           CLOCK,
  input  wire logic                           rst_n,
  input  wire logic [cpu_pkg::reg_addr_w-1:0] rs1,
  input  wire logic [cpu_pkg::reg_addr_w-1:0] rs2,
  output logic      [cpu_pkg::xlen-1:0]       rs1_data,
  output logic      [cpu_pkg::xlen-1:0]       rs2_data,
  fwd_if.rf_sink                              wr
);

  logic [cpu_pkg::xlen-1:0] regs [0:cpu_pkg::zero_reg-1];
  logic                     wr_en;

  assign wr_en = wr.wb_reg_write && (wr.wb_rd != cpu_pkg::reg_addr_w'(cpu_pkg::zero_reg));

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < cpu_pkg::zero_reg; i++) begin
        regs[i] <= {{(cpu_pkg::xlen-32){1'b0}}, i}; // Register i starts at i
      end
    end else if (wr_en) begin
      regs[wr.wb_rd] <= wr.wb_data;
    end
  end

  // Write-first: a read of the register being written sees the new value
  always_comb begin
    if (rs1 == cpu_pkg::reg_addr_w'(cpu_pkg::zero_reg)) rs1_data = '0;
    else if (wr_en && wr.wb_rd == rs1) rs1_data = wr.wb_data;
    else rs1_data = regs[rs1];
    if (rs2 == cpu_pkg::reg_addr_w'(cpu_pkg::zero_reg)) rs2_data = '0;
    else if (wr_en && wr.wb_rd == rs2) rs2_data = wr.wb_data;
    else rs2_data = regs[rs2];
  end

endmodule

`default_nettype wire

//--- tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

  localparam int                       clk_period   = 8;
  localparam int                       reset_cycles = 16;
  localparam int                       prog_len     = 31;
  localparam logic [cpu_pkg::xlen-1:0] start_pc     = 64'h40;

  logic                     CLOCK;
  logic                     rst_n;
  logic [31:0]              instr;
  logic [cpu_pkg::xlen-1:0] mem_rdata;
  logic [cpu_pkg::xlen-1:0] pc, mem_addr, mem_wdata;
  logic                     mem_read, mem_write;

  logic [31:0]              imem [prog_len];
  logic [cpu_pkg::xlen-1:0] dmem [128];

  cpu_top #(.reset_pc(start_pc)) i_cpu_top (
    .CLOCK(CLOCK), .rst_n(rst_n), .instr(instr), .mem_rdata(mem_rdata), .pc(pc),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_read(mem_read), .mem_write(mem_write)
  );

  bind cpu_top cpu_asserts #(.reset_pc(reset_pc)) i_cpu_asserts (
    .CLOCK(CLOCK), .rst_n(rst_n), .pc(pc), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_read(mem_read), .mem_write(mem_write), .stall(stall), .redirect(redirect),
    .redirect_pc(redirect_pc)
  );

  function automatic logic [31:0] r_type(input logic [10:0] op, input logic [4:0] rm, rn, rd);
    return {op, rm, 6'd0, rn, rd};
  endfunction

  function automatic logic [31:0] i_type(input logic [9:0] op, input int imm,
                                         input logic [4:0] rn, rd);
    return {op, imm[11:0], rn, rd};
  endfunction

  function automatic logic [31:0] d_type(input logic [10:0] op, input int imm,
                                         input logic [4:0] rn, rt);
    return {op, imm[8:0], 2'b00, rn, rt};
  endfunction

  function automatic logic [31:0] cb_type(input logic [7:0] op, input int imm,
                                          input logic [4:0] rt);
    return {op, imm[18:0], rt};
  endfunction

  function automatic logic [31:0] b_type(input int imm);
    return {cpu_pkg::op_b, imm[25:0]};
  endfunction

  function automatic logic [31:0] fetch_word(input logic [cpu_pkg::xlen-1:0] addr);
    logic [cpu_pkg::xlen-1:0] idx;
    idx = (addr - start_pc) >> 2;
    if (addr < start_pc || idx >= prog_len) return 32'h0; // Decodes as a bubble
    return imem[idx];
  endfunction

  task automatic load_program();
    imem[0]  = i_type(cpu_pkg::op_addi, 10, 2, 1);     // x1 = 12
    imem[1]  = d_type(cpu_pkg::op_stur, 0, 31, 1);
    imem[2]  = r_type(cpu_pkg::op_add, 4, 1, 3);       // x3 = 16
    imem[3]  = d_type(cpu_pkg::op_stur, 8, 31, 3);
    imem[4]  = r_type(cpu_pkg::op_sub, 1, 3, 5);       // x5 = 16 - 12
    imem[5]  = d_type(cpu_pkg::op_stur, 16, 31, 5);
    imem[6]  = r_type(cpu_pkg::op_and, 26, 1, 6);      // 12 & 26 = 8
    imem[7]  = d_type(cpu_pkg::op_stur, 24, 31, 6);
    imem[8]  = r_type(cpu_pkg::op_orr, 17, 6, 7);      // 8 | 17 = 25
    imem[9]  = d_type(cpu_pkg::op_stur, 32, 31, 7);
    imem[10] = i_type(cpu_pkg::op_addi, 7, 2, 31);     // Lost in x31
    imem[11] = d_type(cpu_pkg::op_stur, 40, 31, 31);
    imem[12] = d_type(cpu_pkg::op_ldur, 48, 31, 8);    // Word 6 holds 30
    imem[13] = i_type(cpu_pkg::op_addi, 3, 8, 9);
    imem[14] = d_type(cpu_pkg::op_stur, 56, 31, 9);
    imem[15] = cb_type(cpu_pkg::op_cbz, 2, 10);        // Falls through
    imem[16] = d_type(cpu_pkg::op_stur, 64, 31, 10);
    imem[17] = cb_type(cpu_pkg::op_cbz, 4, 31);        // Taken to 21
    imem[18] = d_type(cpu_pkg::op_stur, 72, 31, 11);
    imem[19] = d_type(cpu_pkg::op_stur, 80, 31, 12);
    imem[20] = d_type(cpu_pkg::op_stur, 88, 31, 13);
    imem[21] = d_type(cpu_pkg::op_stur, 96, 31, 14);
    imem[22] = b_type(4);                              // To 26
    imem[23] = d_type(cpu_pkg::op_stur, 112, 31, 16);
    imem[24] = b_type(5);                              // To 29
    imem[25] = d_type(cpu_pkg::op_stur, 120, 31, 17);
    imem[26] = b_type(-3);                             // Back to 23
    imem[27] = d_type(cpu_pkg::op_stur, 128, 31, 18);
    imem[28] = d_type(cpu_pkg::op_stur, 136, 31, 19);
    imem[29] = d_type(cpu_pkg::op_stur, 144, 31, 20);
    imem[30] = b_type(0);                              // Spin here
  endtask

  task automatic report_first_error();
    if (i_cpu_top.i_cpu_asserts.fail_is_value)
      $display("error: test %s expected %0d actual %0d", i_cpu_top.i_cpu_asserts.fail_test,
               i_cpu_top.i_cpu_asserts.fail_exp, i_cpu_top.i_cpu_asserts.fail_act);
    else
      $display("error: %s", i_cpu_top.i_cpu_asserts.fail_text);
  endtask

  initial begin
    CLOCK = 1'b0;
    forever #(clk_period / 2) CLOCK = ~CLOCK;
  end

  // Memory reads settle by the falling edge
  always @(negedge CLOCK) begin
    instr     <= fetch_word(pc);
    mem_rdata <= mem_read ? dmem[mem_addr[9:3]] : '0;
  end

  always @(posedge CLOCK) begin
    if (mem_write) dmem[mem_addr[9:3]] <= mem_wdata;
  end

  always @(negedge CLOCK) begin
    if (i_cpu_top.i_cpu_asserts.fail_count != 0) begin
      report_first_error();
      $display("Result: FAILED");
      $fatal(1, "stopped at the first error");
    end
  end

  initial begin
    #(clk_period * (reset_cycles + 40 * prog_len));
    $display("error: timeout, the program never reached its last store");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_n     = 1'b0;
    instr     = '0;
    mem_rdata = '0;
    for (int i = 0; i < 128; i++) dmem[i] = cpu_pkg::xlen'(5 * i);
    load_program();
    repeat (reset_cycles) @(negedge CLOCK);
    rst_n = 1'b1;
    while (i_cpu_top.i_cpu_asserts.store_idx < i_cpu_top.i_cpu_asserts.n_stores)
      @(negedge CLOCK);
    repeat (8) @(negedge CLOCK); // Room for a stray store
    if (i_cpu_top.i_cpu_asserts.fail_count != 0) begin
      report_first_error();
      $display("Result: FAILED");
      $fatal(1, "stopped after the last store");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
